//--- looper_backend.f
+incdir+.
looper_backend_pkg.sv
reg_file.sv
operand_stage.sv
alu_unit.sv
mult_unit.sv
looper_backend.sv
looper_backend_asserts.sv
tb_looper_backend.sv

//--- looper_backend_patterns.txt
// columns: gap lane op src1 src2 imm_vld imm dst reg_wrt tag expected, all hex
// lane 0 alu1, 1 alu2, 2 mult, f ends the list; gap 0 issues with the line above
1 0 7 00 00 1 1234 01 1 01 1234
0 1 7 00 00 1 00f0 02 1 02 00f0
1 0 7 00 00 1 ffff 03 1 03 ffff
0 1 7 00 00 1 0003 04 1 04 0003
2 0 0 01 02 0 0000 05 1 05 1324
0 1 1 02 01 0 0000 06 1 06 eebc
1 0 2 01 02 0 0000 07 1 07 0030
0 1 3 01 02 0 0000 08 1 08 12f4
1 0 4 01 03 0 0000 09 1 09 edcb
0 1 5 01 04 0 0000 0a 1 0a 91a0
1 0 6 03 04 0 0000 0b 1 0b 1fff
0 1 0 03 04 0 0000 0c 1 0c 0002
1 1 0 01 00 1 0010 0d 1 0d 1244
0 0 1 01 00 1 1235 0e 1 0e ffff
1 1 2 03 00 1 0f0f 0f 1 0f 0f0f
0 0 3 02 00 1 0f00 10 1 10 0ff0
1 1 4 01 00 1 ffff 11 1 11 edcb
0 0 5 04 00 1 0014 12 1 12 0030
1 1 6 01 00 1 0004 13 1 13 0123
0 0 7 00 02 0 0000 14 1 14 00f0
1 2 0 01 04 0 0000 15 1 15 369c
0 0 0 05 06 0 0000 16 1 16 01e0
0 1 1 09 00 1 0001 17 1 17 edca
2 0 4 16 17 0 0000 18 1 18 ec2a
2 1 0 15 00 1 0001 19 1 19 369d
1 2 0 03 00 1 1234 1a 1 1a edcc
1 0 7 00 00 1 beef 01 0 1b beef
2 1 0 01 00 1 0000 1c 1 1c 1234
2 0 0 1a 19 0 0000 1d 1 1d 2469
0 f 0 00 00 0 0000 00 0 00 0000

//--- tb_looper_backend.sv
`timescale 1ns/1ps

`include "looper_backend_params.svh"

module tb_looper_backend;

   localparam int FIELDS    = 11;
   localparam int MAX_LINES = 64;
   localparam int ALU_LAT   = 2;
   localparam int MULT_LAT  = 1 + `MULT_CYCLES;

   typedef struct packed {
      looper_backend_pkg::cmpl_t cmpl;
      int                        due;
   } exp_t;

   logic                           clk;
   logic                           rst;
   looper_backend_pkg::issue_pkt_t alu1_iss;
   looper_backend_pkg::issue_pkt_t alu2_iss;
   looper_backend_pkg::issue_pkt_t mult_iss;
   looper_backend_pkg::cmpl_t      alu1_cmpl;
   looper_backend_pkg::cmpl_t      alu2_cmpl;
   looper_backend_pkg::cmpl_t      mult_cmpl;
   logic                           mult_rdy;

   logic [15:0]                    pat_mem [FIELDS*MAX_LINES];
   // issue group being collected in lane order alu1, alu2, mult
   looper_backend_pkg::issue_pkt_t pend [3];
   looper_backend_pkg::data_t      pend_res [3];
   exp_t                           alu1_q [$];
   exp_t                           alu2_q [$];
   exp_t                           mult_q [$];
   int                             edge_cnt = 0;
   int                             last_mult_edge = -100;
   int                             value_errs = 0;
   int                             other_errs = 0;
   int                             wd_cycles = 0;
   logic                           checking = 1'b0;

   looper_backend UUT (
      .clk       (clk),
      .rst       (rst),
      .alu1_iss  (alu1_iss),
      .alu2_iss  (alu2_iss),
      .mult_iss  (mult_iss),
      .alu1_cmpl (alu1_cmpl),
      .alu2_cmpl (alu2_cmpl),
      .mult_cmpl (mult_cmpl),
      .mult_rdy  (mult_rdy)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      edge_cnt <= edge_cnt + 1;
   end

   function automatic int q_size(input int lane);
      case (lane)
         0: return alu1_q.size();
         1: return alu2_q.size();
         default: return mult_q.size();
      endcase
   endfunction

   function automatic int front_due(input int lane);
      case (lane)
         0: return alu1_q[0].due;
         1: return alu2_q[0].due;
         default: return mult_q[0].due;
      endcase
   endfunction

   function automatic exp_t pop_expected(input int lane);
      exp_t e;
      case (lane)
         0: e = alu1_q.pop_front();
         1: e = alu2_q.pop_front();
         default: e = mult_q.pop_front();
      endcase
      return e;
   endfunction

   task automatic push_expected(input int lane, input exp_t e);
      case (lane)
         0: alu1_q.push_back(e);
         1: alu2_q.push_back(e);
         default: mult_q.push_back(e);
      endcase
   endtask

   // low from the edge after a multiply issue up to its completion edge
   function automatic logic expected_rdy();
      return !(edge_cnt > last_mult_edge && edge_cnt <= last_mult_edge + `MULT_CYCLES);
   endfunction

   task automatic check_cmpl(
      input looper_backend_pkg::cmpl_t got,
      input looper_backend_pkg::cmpl_t exp,
      input int                        due
   );
      if (got !== exp) begin
         $display("[FAIL] %0t: tag %0h got vld %b wrt %b dst %0h data %h, expected %b %b %0h %h",
                  $time, exp.tag, got.vld, got.reg_wrt, got.dst, got.data,
                  exp.vld, exp.reg_wrt, exp.dst, exp.data);
         value_errs++;
      end
      if (edge_cnt != due) begin
         $display("[FAIL] %0t: tag %0h completed at edge %0d, expected edge %0d",
                  $time, exp.tag, edge_cnt, due);
         value_errs++;
      end
   endtask

   task automatic check_rdy(input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %0t: mult_rdy is %b, expected %b", $time, got, exp);
         value_errs++;
      end
   endtask

   task automatic watch_lane(input int lane, input looper_backend_pkg::cmpl_t got);
      exp_t e;
      if (got.vld !== 1'b0) begin
         if (q_size(lane) == 0) begin
            $display("unexpected completion on lane %0d at %0t, tag %0h", lane, $time, got.tag);
            other_errs++;
         end else begin
            e = pop_expected(lane);
            check_cmpl(got, e.cmpl, e.due);
         end
      end else if (q_size(lane) > 0 && front_due(lane) <= edge_cnt) begin
         e = pop_expected(lane);
         $display("missing completion on lane %0d: tag %0h was due at edge %0d",
                  lane, e.cmpl.tag, e.due);
         other_errs++;
      end
   endtask

   // registered outputs are settled by the falling edge
   always @(negedge clk) begin
      if (checking) begin
         watch_lane(0, alu1_cmpl);
         watch_lane(1, alu2_cmpl);
         watch_lane(2, mult_cmpl);
         check_rdy(mult_rdy, expected_rdy());
      end
   end

   task automatic issue_group();
      exp_t e;
      while (pend[2].vld && (!mult_rdy || last_mult_edge == edge_cnt)) begin
         @(posedge clk);
         #1;
      end
      alu1_iss = pend[0];
      alu2_iss = pend[1];
      mult_iss = pend[2];
      @(posedge clk);
      #1;
      for (int l = 0; l < 3; l++) begin
         if (pend[l].vld) begin
            e.cmpl.vld     = 1'b1;
            e.cmpl.reg_wrt = pend[l].reg_wrt;
            e.cmpl.dst     = pend[l].dst;
            e.cmpl.data    = pend_res[l];
            e.cmpl.tag     = pend[l].tag;
            e.due          = edge_cnt + ((l == 2) ? MULT_LAT : ALU_LAT);
            push_expected(l, e);
         end
      end
      if (pend[2].vld) begin
         last_mult_edge = edge_cnt;
      end
      alu1_iss = '0;
      alu2_iss = '0;
      mult_iss = '0;
      for (int l = 0; l < 3; l++) begin
         pend[l] = '0;
      end
   endtask

   initial begin
      looper_backend_pkg::issue_pkt_t pkt;
      int   base;
      int   gap;
      int   lane;
      int   idle_cycles;
      int   gap_sum;
      int   n_lines;
      logic first;

      void'($urandom(31));
      rst      = 1'b1;
      alu1_iss = '0;
      alu2_iss = '0;
      mult_iss = '0;
      for (int l = 0; l < 3; l++) begin
         pend[l]     = '0;
         pend_res[l] = '0;
      end

      $readmemh("looper_backend_patterns.txt", pat_mem);
      n_lines = 0;
      gap_sum = 0;
      while (n_lines < MAX_LINES && pat_mem[n_lines*FIELDS+1] != 16'h000f) begin
         gap_sum += int'(pat_mem[n_lines*FIELDS]);
         n_lines++;
      end
      if (n_lines == 0) begin
         $display("no pattern lines read from looper_backend_patterns.txt");
         other_errs++;
      end
      wd_cycles = gap_sum + 3 * n_lines + 50;

      repeat (2) @(posedge clk);
      #1;
      rst      = 1'b0;
      // first checked cycle shows the reset state
      checking = 1'b1;

      first = 1'b1;
      for (int i = 0; i < n_lines; i++) begin
         base = i * FIELDS;
         gap  = int'(pat_mem[base]);
         lane = int'(pat_mem[base+1]);
         if (lane > 2) begin
            $display("pattern line %0d names lane %0d, which does not exist", i, lane);
            other_errs++;
         end else begin
            if (!first && (gap != 0 || pend[lane].vld)) begin
               issue_group();
               idle_cycles = ((gap == 0) ? 1 : gap) - 1 + int'($urandom % 3);
               repeat (idle_cycles) begin
                  @(posedge clk);
                  #1;
               end
            end
            pkt.vld       = 1'b1;
            pkt.op        = looper_backend_pkg::alu_op_e'(pat_mem[base+2][2:0]);
            pkt.src1      = pat_mem[base+3][`PREG_W-1:0];
            pkt.src2      = pat_mem[base+4][`PREG_W-1:0];
            pkt.imm_vld   = pat_mem[base+5][0];
            pkt.imm       = pat_mem[base+6];
            pkt.dst       = pat_mem[base+7][`PREG_W-1:0];
            pkt.reg_wrt   = pat_mem[base+8][0];
            pkt.tag       = pat_mem[base+9][`TAG_W-1:0];
            pend[lane]     = pkt;
            pend_res[lane] = pat_mem[base+10];
            first          = 1'b0;
         end
      end
      if (!first) begin
         issue_group();
      end

      while (q_size(0) + q_size(1) + q_size(2) > 0) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk);

      $display("errors: %0d wrong value, %0d missing or unexpected, %0d assertion",
               value_errs, other_errs, UUT.u_asserts.fail_cnt);
      if (value_errs == 0 && other_errs == 0 && UUT.u_asserts.fail_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk);
      $display("timeout: run did not finish within %0d cycles", wd_cycles);
      $display("errors: %0d wrong value, %0d missing or unexpected, %0d assertion",
               value_errs, other_errs, UUT.u_asserts.fail_cnt);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- looper_backend_asserts.sv
`timescale 1ns/1ps

module looper_backend_asserts (
   input logic                           clk,
   input logic                           rst,
   input looper_backend_pkg::issue_pkt_t alu1_iss,
   input looper_backend_pkg::issue_pkt_t alu2_iss,
   input looper_backend_pkg::issue_pkt_t mult_iss,
   input looper_backend_pkg::cmpl_t      alu1_cmpl,
   input looper_backend_pkg::cmpl_t      alu2_cmpl,
   input looper_backend_pkg::cmpl_t      mult_cmpl,
   input logic                           mult_rdy
);

   int fail_cnt = 0;

   function automatic logic dst_clash(
      input looper_backend_pkg::cmpl_t a,
      input looper_backend_pkg::cmpl_t b
   );
      return a.vld && a.reg_wrt && b.vld && b.reg_wrt && (a.dst == b.dst);
   endfunction

   cmpl_idle_after_rst: assert property (@(posedge clk)
      rst |=> !alu1_cmpl.vld && !alu2_cmpl.vld && !mult_cmpl.vld)
      else begin
         $error("completion valid in the cycle after reset");
         fail_cnt++;
      end

   mult_issue_legal: assert property (@(posedge clk) disable iff (rst)
      mult_iss.vld |-> mult_rdy)
      else begin
         $error("multiply issued while mult_rdy is low");
         fail_cnt++;
      end

   // completion register loads two edges after issue and is sampled one edge later
   alu1_latency: assert property (@(posedge clk) disable iff (rst)
      alu1_iss.vld |-> ##3 (alu1_cmpl.vld && alu1_cmpl.tag == $past(alu1_iss.tag, 3)))
      else begin
         $error("alu1 completion not two edges after issue");
         fail_cnt++;
      end

   alu2_latency: assert property (@(posedge clk) disable iff (rst)
      alu2_iss.vld |-> ##3 (alu2_cmpl.vld && alu2_cmpl.tag == $past(alu2_iss.tag, 3)))
      else begin
         $error("alu2 completion not two edges after issue");
         fail_cnt++;
      end

   no_dst_clash: assert property (@(posedge clk) disable iff (rst)
      !(dst_clash(alu1_cmpl, alu2_cmpl) || dst_clash(alu1_cmpl, mult_cmpl) ||
        dst_clash(alu2_cmpl, mult_cmpl)))
      else begin
         $error("two completions write the same register in one cycle");
         fail_cnt++;
      end

endmodule

bind looper_backend looper_backend_asserts u_asserts (
   .clk       (clk),
   .rst       (rst),
   .alu1_iss  (alu1_iss),
   .alu2_iss  (alu2_iss),
   .mult_iss  (mult_iss),
   .alu1_cmpl (alu1_cmpl),
   .alu2_cmpl (alu2_cmpl),
   .mult_cmpl (mult_cmpl),
   .mult_rdy  (mult_rdy)
);

//--- looper_backend.sv
`timescale 1ns/1ps

module looper_backend (
   input  logic                           clk,
   input  logic                           rst,
   input  looper_backend_pkg::issue_pkt_t alu1_iss,
   input  looper_backend_pkg::issue_pkt_t alu2_iss,
   input  looper_backend_pkg::issue_pkt_t mult_iss,
   output looper_backend_pkg::cmpl_t      alu1_cmpl,
   output looper_backend_pkg::cmpl_t      alu2_cmpl,
   output looper_backend_pkg::cmpl_t      mult_cmpl,
   output logic                           mult_rdy
);

   // operand stage to register file
   looper_backend_pkg::preg_t rd_addr [6];
   looper_backend_pkg::data_t rd_data [6];

   // operand stage to units
   looper_backend_pkg::exec_pkt_t alu1_exe;
   looper_backend_pkg::exec_pkt_t alu2_exe;
   looper_backend_pkg::exec_pkt_t mult_exe;

   // write ports, mult last so it wins
   looper_backend_pkg::cmpl_t wr_cmpl [3];

   assign wr_cmpl[0] = alu1_cmpl;
   assign wr_cmpl[1] = alu2_cmpl;
   assign wr_cmpl[2] = mult_cmpl;

   operand_stage u_opnd (
      .clk      (clk),
      .rst      (rst),
      .alu1_iss (alu1_iss),
      .alu2_iss (alu2_iss),
      .mult_iss (mult_iss),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .alu1_exe (alu1_exe),
      .alu2_exe (alu2_exe),
      .mult_exe (mult_exe)
   );

   reg_file u_rf (
      .clk     (clk),
      .rst     (rst),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .wr_cmpl (wr_cmpl)
   );

   alu_unit u_alu1 (
      .clk  (clk),
      .rst  (rst),
      .exe  (alu1_exe),
      .cmpl (alu1_cmpl)
   );

   alu_unit u_alu2 (
      .clk  (clk),
      .rst  (rst),
      .exe  (alu2_exe),
      .cmpl (alu2_cmpl)
   );

   mult_unit u_mult (
      .clk      (clk),
      .rst      (rst),
      .exe      (mult_exe),
      .cmpl     (mult_cmpl),
      .mult_rdy (mult_rdy)
   );

endmodule

//--- mult_unit.sv
`timescale 1ns/1ps

`include "looper_backend_params.svh"

module mult_unit (
   input  logic                          clk,
   input  logic                          rst,
   input  looper_backend_pkg::exec_pkt_t exe,
   output looper_backend_pkg::cmpl_t     cmpl,
   output logic                          mult_rdy
);

   localparam int CNT_W = $clog2(`MULT_CYCLES);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MULT_CYCLES - 2);

   looper_backend_pkg::mult_state_e state;
   logic [CNT_W-1:0]                cnt;
   logic                            start;
   logic                            done;

   looper_backend_pkg::data_t op_a;
   looper_backend_pkg::data_t op_b;
   looper_backend_pkg::preg_t dst_q;
   logic                      reg_wrt_q;
   looper_backend_pkg::tag_t  tag_q;

   assign start    = (state == looper_backend_pkg::MULT_IDLE) && exe.vld;
   assign done     = (state == looper_backend_pkg::MULT_BUSY) && (cnt == CNT_LAST);
   assign mult_rdy = (state == looper_backend_pkg::MULT_IDLE) && !exe.vld;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= looper_backend_pkg::MULT_IDLE;
         cnt   <= '0;
      end else if (start) begin
         state <= looper_backend_pkg::MULT_BUSY;
         cnt   <= '0;
      end else if (done) begin
         state <= looper_backend_pkg::MULT_IDLE;
      end else if (state == looper_backend_pkg::MULT_BUSY) begin
         cnt <= cnt + 1'b1;
      end
   end

   // op field is not used on this lane
   always_ff @(posedge clk) begin
      if (start) begin
         op_a      <= exe.opa;
         op_b      <= exe.opb;
         dst_q     <= exe.dst;
         reg_wrt_q <= exe.reg_wrt;
         tag_q     <= exe.tag;
      end
   end

   // low half of the product only
   always_ff @(posedge clk) begin
      cmpl.reg_wrt <= reg_wrt_q;
      cmpl.dst     <= dst_q;
      cmpl.data    <= op_a * op_b;
      cmpl.tag     <= tag_q;
      if (rst) begin
         cmpl.vld <= 1'b0;
      end else begin
         cmpl.vld <= done;
      end
   end

endmodule

//--- alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
   input  logic                          clk,
   input  logic                          rst,
   input  looper_backend_pkg::exec_pkt_t exe,
   output looper_backend_pkg::cmpl_t     cmpl
);

   looper_backend_pkg::data_t result;

   always_comb begin
      case (exe.op)
         looper_backend_pkg::OP_ADD: result = exe.opa + exe.opb;
         looper_backend_pkg::OP_SUB: result = exe.opa - exe.opb;
         looper_backend_pkg::OP_AND: result = exe.opa & exe.opb;
         looper_backend_pkg::OP_OR:  result = exe.opa | exe.opb;
         looper_backend_pkg::OP_XOR: result = exe.opa ^ exe.opb;
         // shift amount from low nibble only
         looper_backend_pkg::OP_SLL: result = exe.opa << exe.opb[3:0];
         looper_backend_pkg::OP_SRL: result = exe.opa >> exe.opb[3:0];
         looper_backend_pkg::OP_LDI: result = exe.opb;
         default:                    result = '0;
      endcase
   end

   // completion doubles as the write port
   always_ff @(posedge clk) begin
      cmpl.reg_wrt <= exe.reg_wrt;
      cmpl.dst     <= exe.dst;
      cmpl.data    <= result;
      cmpl.tag     <= exe.tag;
      if (rst) begin
         cmpl.vld <= 1'b0;
      end else begin
         cmpl.vld <= exe.vld;
      end
   end

endmodule

//--- operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
   input  logic                           clk,
   input  logic                           rst,
   input  looper_backend_pkg::issue_pkt_t alu1_iss,
   input  looper_backend_pkg::issue_pkt_t alu2_iss,
   input  looper_backend_pkg::issue_pkt_t mult_iss,
   output looper_backend_pkg::preg_t      rd_addr [6],
   input  looper_backend_pkg::data_t      rd_data [6],
   output looper_backend_pkg::exec_pkt_t  alu1_exe,
   output looper_backend_pkg::exec_pkt_t  alu2_exe,
   output looper_backend_pkg::exec_pkt_t  mult_exe
);

   // lane order alu1, alu2, mult
   looper_backend_pkg::issue_pkt_t iss_q [3];
   looper_backend_pkg::exec_pkt_t  exe_d [3];
   looper_backend_pkg::exec_pkt_t  exe_q [3];

   function automatic looper_backend_pkg::exec_pkt_t build_exe(
      input looper_backend_pkg::issue_pkt_t iss,
      input looper_backend_pkg::data_t      a,
      input looper_backend_pkg::data_t      b
   );
      looper_backend_pkg::exec_pkt_t e;
      e.vld     = iss.vld;
      e.op      = iss.op;
      e.opa     = a;
      e.opb     = iss.imm_vld ? iss.imm : b;
      e.dst     = iss.dst;
      e.reg_wrt = iss.reg_wrt;
      e.tag     = iss.tag;
      return e;
   endfunction

   // issue boundary
   always_ff @(posedge clk) begin
      iss_q[0] <= alu1_iss;
      iss_q[1] <= alu2_iss;
      iss_q[2] <= mult_iss;
      if (rst) begin
         for (int i = 0; i < 3; i++) begin
            iss_q[i].vld <= 1'b0;
         end
      end
   end

   // two read ports per lane
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         rd_addr[2*i]   = iss_q[i].src1;
         rd_addr[2*i+1] = iss_q[i].src2;
         exe_d[i]       = build_exe(iss_q[i], rd_data[2*i], rd_data[2*i+1]);
      end
   end

   // execute boundary
   always_ff @(posedge clk) begin
      for (int i = 0; i < 3; i++) begin
         exe_q[i] <= exe_d[i];
      end
      if (rst) begin
         for (int i = 0; i < 3; i++) begin
            exe_q[i].vld <= 1'b0;
         end
      end
   end

   assign alu1_exe = exe_q[0];
   assign alu2_exe = exe_q[1];
   assign mult_exe = exe_q[2];

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

`include "looper_backend_params.svh"

module reg_file (
   input  logic                      clk,
   input  logic                      rst,
   input  looper_backend_pkg::preg_t rd_addr [6],
   output looper_backend_pkg::data_t rd_data [6],
   input  looper_backend_pkg::cmpl_t wr_cmpl [3]
);

   looper_backend_pkg::data_t regs [`PREG_NUM];

   // port order alu1, alu2, mult
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `PREG_NUM; i++) begin
            regs[i] <= '0;
         end
      end else begin
         // last matching port wins
         for (int w = 0; w < 3; w++) begin
            if (wr_cmpl[w].vld && wr_cmpl[w].reg_wrt) begin
               regs[wr_cmpl[w].dst] <= wr_cmpl[w].data;
            end
         end
      end
   end

   // write-through with the same port priority as the array write
   always_comb begin
      for (int r = 0; r < 6; r++) begin
         rd_data[r] = regs[rd_addr[r]];
         for (int w = 0; w < 3; w++) begin
            if (wr_cmpl[w].vld && wr_cmpl[w].reg_wrt &&
                wr_cmpl[w].dst == rd_addr[r]) begin
               rd_data[r] = wr_cmpl[w].data;
            end
         end
      end
   end

endmodule

//--- looper_backend_pkg.sv
`include "looper_backend_params.svh"

package looper_backend_pkg;

   typedef logic [`PREG_W-1:0] preg_t;
   typedef logic [`DATA_W-1:0] data_t;
   typedef logic [`TAG_W-1:0]  tag_t;

   // alu opcodes
   typedef enum logic [2:0] {
      OP_ADD = 3'd0,
      OP_SUB = 3'd1,
      OP_AND = 3'd2,
      OP_OR  = 3'd3,
      OP_XOR = 3'd4,
      OP_SLL = 3'd5,
      OP_SRL = 3'd6,
      OP_LDI = 3'd7
   } alu_op_e;

   typedef enum logic {
      MULT_IDLE = 1'b0,
      MULT_BUSY = 1'b1
   } mult_state_e;

   // scheduled instruction as it arrives from outside
   typedef struct packed {
      logic    vld;
      alu_op_e op;
      preg_t   src1;
      preg_t   src2;
      logic    imm_vld;
      data_t   imm;
      preg_t   dst;
      logic    reg_wrt;
      tag_t    tag;
   } issue_pkt_t;

   // operands resolved, opb already holds the immediate if one was used
   typedef struct packed {
      logic    vld;
      alu_op_e op;
      data_t   opa;
      data_t   opb;
      preg_t   dst;
      logic    reg_wrt;
      tag_t    tag;
   } exec_pkt_t;

   typedef struct packed {
      logic  vld;
      logic  reg_wrt;
      preg_t dst;
      data_t data;
      tag_t  tag;
   } cmpl_t;

endpackage

//--- looper_backend_params.svh
`ifndef LOOPER_BACKEND_PARAMS_SVH
`define LOOPER_BACKEND_PARAMS_SVH

// physical register file
`define PREG_NUM 64
`define PREG_W 6

// datapath word
`define DATA_W 16

// reorder tag carried through to completion
`define TAG_W 6

// multiplier latency, capture edge to completion edge plus one
`define MULT_CYCLES 3

`endif
